/* rvm_div.f */
hw/rvm_div_pkg.sv
hw/div_op_decode.sv
hw/div_iter_core.sv
hw/div_result_fmt.sv
hw/div_unit.sv
test/tb_div_unit.sv

/* Makefile */
# Verilator build and run of the RV64M division unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_div_unit
FILELIST  ?= rvm_div.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  build  compile the testbench and RTL with Verilator"
	@echo "  test   build, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "TEST PASSED" || (echo "TEST FAILED"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/tb_div_unit.sv */
`timescale 1ns/1ps
`default_nettype none
//----------------------------------------------------------------------
// Directed testbench for the RV64M division unit
// Checks all divide forms against an ISA reference model, then
// back-pressure, flush and the reset state. Run through the Makefile
//----------------------------------------------------------------------

module tb_div_unit
    import rvm_div_pkg::*;
();

    localparam int CLK_HALF   = 20;
    // Requests issued over all tests, rounded up
    localparam int N_REQ      = 100;
    localparam int RESP_LIMIT = DIV_STEPS + 20;
    localparam int WATCHDOG   = N_REQ * (DIV_STEPS + 20) + 2000;

    localparam logic [2:0] OPS [4] = '{FUNCT3_DIV, FUNCT3_DIVU, FUNCT3_REM, FUNCT3_REMU};

    logic            clk;
    logic            rst_n;
    logic            flush;
    logic            req_valid;
    logic            req_ready;
    logic [2:0]      funct3;
    logic            word;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic            resp_valid;
    logic            resp_ready;
    logic [XLEN-1:0] resp_data;

    logic [31:0]     lfsr;
    int              err_test;
    int              err_total;
    int              tests_run;
    int              tests_failed;

    div_unit u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .funct3     (funct3),
        .word       (word),
        .rs1        (rs1),
        .rs2        (rs2),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_data  (resp_data)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Ends a hung run
    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Watchdog timed out after %0d cycles", WATCHDOG);
        $display("Simulation failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // Stimulus and reference model
    // ------------------------------------------------------------------

    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    // Low word kept, upper half filled with junk
    function automatic logic [63:0] with_junk(input logic [31:0] lo);
        logic [63:0] v;
        v = rand_bits(32);
        return {v[31:0], lo};
    endfunction

    // ISA result of one divide, W forms work on the low words
    function automatic logic [63:0] ref_div(input logic [2:0] f3, input logic w,
                                            input logic [63:0] a, input logic [63:0] b);
        logic        is_signed;
        logic        is_rem;
        logic [31:0] a32;
        logic [31:0] b32;
        logic [31:0] q32;
        logic [31:0] r32;
        logic [63:0] q64;
        logic [63:0] r64;
        is_signed = (f3 == FUNCT3_DIV) || (f3 == FUNCT3_REM);
        is_rem = (f3 == FUNCT3_REM) || (f3 == FUNCT3_REMU);
        a32 = a[31:0];
        b32 = b[31:0];
        if (w) begin
            if (b32 == 32'd0) begin
                q32 = '1;
                r32 = a32;
            end else if (is_signed && a32 == 32'h8000_0000 && b32 == '1) begin
                q32 = a32;
                r32 = '0;
            end else if (is_signed) begin
                q32 = $signed(a32) / $signed(b32);
                r32 = $signed(a32) % $signed(b32);
            end else begin
                q32 = a32 / b32;
                r32 = a32 % b32;
            end
            q64 = {{32{q32[31]}}, q32};
            r64 = {{32{r32[31]}}, r32};
        end else if (b == '0) begin
            q64 = '1;
            r64 = a;
        end else if (is_signed && a == 64'h8000_0000_0000_0000 && b == '1) begin
            q64 = a;
            r64 = '0;
        end else if (is_signed) begin
            q64 = $signed(a) / $signed(b);
            r64 = $signed(a) % $signed(b);
        end else begin
            q64 = a / b;
            r64 = a % b;
        end
        return is_rem ? r64 : q64;
    endfunction

    // ------------------------------------------------------------------
    // Driver and reporting tasks
    // ------------------------------------------------------------------

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic report_value(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
        $display("Error [%s]: expected %h, actual %h", name, exp, act);
        err_test++;
    endtask

    task automatic report_fault(input string name, input string what);
        $display("Error [%s]: %s", name, what);
        err_test++;
    endtask

    // Waits for req_ready, then holds the request over one accept edge
    task automatic issue(input string name, input logic [2:0] f3, input logic w,
                         input logic [63:0] a, input logic [63:0] b);
        int waited;
        waited = 0;
        while (!req_ready && waited < RESP_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!req_ready) begin
            report_fault(name, "req_ready never returned high");
        end
        req_valid = 1'b1;
        funct3 = f3;
        word = w;
        rs1 = a;
        rs2 = b;
        next_cycle();
        req_valid = 1'b0;
    endtask

    task automatic wait_resp(input string name, output logic [63:0] data, output logic got);
        int waited;
        waited = 0;
        while (!resp_valid && waited < RESP_LIMIT) begin
            next_cycle();
            waited++;
        end
        got = resp_valid;
        data = resp_data;
        if (!got) begin
            report_fault(name, "no response within the expected latency");
        end
    endtask

    // Full request/response round trip with resp_ready high
    task automatic run_op(input string name, input logic [2:0] f3, input logic w,
                          input logic [63:0] a, input logic [63:0] b, input logic [63:0] exp);
        logic [63:0] data;
        logic        got;
        issue(name, f3, w, a, b);
        wait_resp(name, data, got);
        next_cycle();
        if (got && data !== exp) begin
            report_value(name, exp, data);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        err_total += err_test;
        if (err_test == 0) begin
            $display("Test %s: pass", name);
        end else begin
            tests_failed++;
            $display("Test %s: FAIL with %0d errors", name, err_test);
        end
        err_test = 0;
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------

    task automatic test_reset_state();
        if (resp_valid !== 1'b0) begin
            report_fault("reset_state", "resp_valid is high after reset");
        end
        if (req_ready !== 1'b1) begin
            report_fault("reset_state", "req_ready is low after reset");
        end
        finish_test("reset_state");
    endtask

    // Every sign combination, then random magnitudes and signs
    task automatic test_doubleword();
        logic [63:0] a;
        logic [63:0] b;
        for (int p = 0; p < 10; p++) begin
            if (p < 4) begin
                a = p[0] ? -64'sd100 : 64'sd100;
                b = p[1] ? -64'sd7 : 64'sd7;
            end else begin
                a = rand_bits(64);
                b = rand_bits(64);
                b = b >> rand_bits(6);
                if (rand_bits(1) != 0) begin
                    b = -b;
                end
            end
            for (int k = 0; k < 4; k++) begin
                run_op($sformatf("doubleword f3=%0d", OPS[k]), OPS[k], 1'b0, a, b,
                       ref_div(OPS[k], 1'b0, a, b));
            end
        end
        finish_test("doubleword");
    endtask

    // Upper halves are junk and must not matter
    task automatic test_word();
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        for (int p = 0; p < 10; p++) begin
            if (p < 4) begin
                a = with_junk(p[0] ? 32'hffff_ff9c : 32'd100);
                b = with_junk(p[1] ? 32'hffff_fff9 : 32'd7);
            end else begin
                r = rand_bits(32);
                a = with_junk(r[31:0]);
                r = rand_bits(32);
                r = r >> rand_bits(5);
                b = with_junk(r[31:0]);
            end
            for (int k = 0; k < 4; k++) begin
                run_op($sformatf("word f3=%0d", OPS[k]), OPS[k], 1'b1, a, b,
                       ref_div(OPS[k], 1'b1, a, b));
            end
        end
        finish_test("word");
    endtask

    // Expected values written out from the ISA table
    task automatic test_special();
        logic [63:0] a;
        logic [63:0] aw;
        logic [63:0] bw;
        a = rand_bits(64);
        aw = with_junk(32'h8765_4321);
        bw = with_junk(32'h0);
        // Divide by zero
        for (int k = 0; k < 4; k++) begin
            run_op("special div0", OPS[k], 1'b0, a, 64'h0, k < 2 ? '1 : a);
            run_op("special div0 w", OPS[k], 1'b1, aw, bw,
                   k < 2 ? '1 : 64'hffff_ffff_8765_4321);
        end
        // Most negative over minus one
        run_op("special ovf", FUNCT3_DIV, 1'b0, 64'h8000_0000_0000_0000, '1,
               64'h8000_0000_0000_0000);
        run_op("special ovf", FUNCT3_REM, 1'b0, 64'h8000_0000_0000_0000, '1, 64'h0);
        aw = with_junk(32'h8000_0000);
        bw = with_junk(32'hffff_ffff);
        run_op("special ovf w", FUNCT3_DIV, 1'b1, aw, bw, 64'hffff_ffff_8000_0000);
        run_op("special ovf w", FUNCT3_REM, 1'b1, aw, bw, 64'h0);
        finish_test("special");
    endtask

    task automatic test_backpressure();
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] held;
        logic        got;
        int          hold;
        a = rand_bits(64);
        b = rand_bits(40);
        resp_ready = 1'b0;
        issue("backpressure", FUNCT3_REM, 1'b0, a, b);
        wait_resp("backpressure", held, got);
        hold = 3 + int'(rand_bits(4));
        repeat (hold) begin
            next_cycle();
            if (resp_data !== held) begin
                report_value("backpressure", held, resp_data);
            end
            if (!resp_valid) begin
                report_fault("backpressure", "resp_valid dropped while resp_ready was low");
            end
            if (req_ready) begin
                report_fault("backpressure", "req_ready high with a response pending");
            end
        end
        resp_ready = 1'b1;
        next_cycle();
        if (resp_valid || !req_ready) begin
            report_fault("backpressure", "response not consumed once resp_ready rose");
        end
        if (got && held !== ref_div(FUNCT3_REM, 1'b0, a, b)) begin
            report_value("backpressure", ref_div(FUNCT3_REM, 1'b0, a, b), held);
        end
        // Next request after the stall
        run_op("backpressure next", FUNCT3_DIVU, 1'b0, b, 64'd13,
               ref_div(FUNCT3_DIVU, 1'b0, b, 64'd13));
        finish_test("backpressure");
    endtask

    task automatic test_flush();
        logic [63:0] a;
        logic [63:0] b;
        logic        seen;
        a = rand_bits(64);
        b = rand_bits(48);
        issue("flush", FUNCT3_DIV, 1'b0, a, b);
        repeat (10 + int'(rand_bits(5))) next_cycle();
        flush = 1'b1;
        next_cycle();
        flush = 1'b0;
        if (!req_ready) begin
            report_fault("flush", "req_ready still low after the flush");
        end
        // Request together with flush is dropped
        flush = 1'b1;
        req_valid = 1'b1;
        funct3 = FUNCT3_DIVU;
        word = 1'b0;
        rs1 = a;
        rs2 = 64'd0;
        next_cycle();
        flush = 1'b0;
        req_valid = 1'b0;
        seen = 1'b0;
        repeat (RESP_LIMIT) begin
            next_cycle();
            seen = seen | resp_valid;
        end
        if (seen) begin
            report_fault("flush", "a response appeared for a flushed request");
        end
        run_op("flush next", FUNCT3_REMU, 1'b0, a, b, ref_div(FUNCT3_REMU, 1'b0, a, b));
        finish_test("flush");
    endtask

    initial begin
        lfsr = 32'h9dad966f;
        err_test = 0;
        err_total = 0;
        tests_run = 0;
        tests_failed = 0;
        rst_n = 1'b0;
        flush = 1'b0;
        req_valid = 1'b0;
        funct3 = FUNCT3_DIV;
        word = 1'b0;
        rs1 = '0;
        rs2 = '0;
        resp_ready = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();

        test_reset_state();
        test_doubleword();
        test_word();
        test_special();
        test_backpressure();
        test_flush();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total);
        if (err_total == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/div_unit.sv */
`timescale 1ns/1ps
`default_nettype none
//--------------------------------------------------------------------
// RV64M division unit for the execute stage
// Request/response handshake on both sides, flush abandons a divide
//--------------------------------------------------------------------

module div_unit
    import rvm_div_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    // Request side
    input  logic            req_valid,
    output logic            req_ready,
    input  logic [2:0]      funct3,
    input  logic            word,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    // Response side
    output logic            resp_valid,
    input  logic            resp_ready,
    output logic [XLEN-1:0] resp_data
);

    // Decoder to core
    logic [XLEN-1:0] dividend;
    logic [XLEN-1:0] divisor;
    logic            div_signed;
    logic            div_valid;

    // Decoder to formatter
    logic            rem_sel;
    logic            word_op;

    // Core results
    logic            out_valid;
    logic [XLEN-1:0] quotient;
    logic [XLEN-1:0] remainder;

    // Formatter back to decoder
    logic            res_busy;

    div_op_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .req_valid  (req_valid),
        .funct3     (funct3),
        .word       (word),
        .rs1        (rs1),
        .rs2        (rs2),
        .out_valid  (out_valid),
        .res_busy   (res_busy),
        .req_ready  (req_ready),
        .dividend   (dividend),
        .divisor    (divisor),
        .div_signed (div_signed),
        .div_valid  (div_valid),
        .rem_sel    (rem_sel),
        .word_op    (word_op)
    );

    div_iter_core u_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .div_valid  (div_valid),
        .div_signed (div_signed),
        .dividend   (dividend),
        .divisor    (divisor),
        .out_valid  (out_valid),
        .quotient   (quotient),
        .remainder  (remainder)
    );

    div_result_fmt u_fmt (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .out_valid  (out_valid),
        .rem_sel    (rem_sel),
        .word_op    (word_op),
        .quotient   (quotient),
        .remainder  (remainder),
        .resp_ready (resp_ready),
        .resp_valid (resp_valid),
        .res_busy   (res_busy),
        .resp_data  (resp_data)
    );

endmodule

`default_nettype wire

/* hw/div_result_fmt.sv */
`timescale 1ns/1ps
`default_nettype none
//--------------------------------------------------------------------
// Result formatting and response buffer of the divider
// Picks quotient or remainder, sign-extends W results and holds
// the response until downstream takes it
//--------------------------------------------------------------------

module div_result_fmt
    import rvm_div_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            out_valid,
    input  logic            rem_sel,
    input  logic            word_op,
    input  logic [XLEN-1:0] quotient,
    input  logic [XLEN-1:0] remainder,
    input  logic            resp_ready,
    output logic            resp_valid,
    output logic            res_busy,
    output logic [XLEN-1:0] resp_data
);

    // ------------------------------------------------------------------
    // Formatting
    // ------------------------------------------------------------------

    logic [XLEN-1:0] sel_data;
    logic [XLEN-1:0] fmt_data;

    // Quotient for DIV forms, remainder for REM forms
    assign sel_data = rem_sel ? remainder : quotient;

    // W results are sign-extended from bit 31
    // Holds for the unsigned W forms too
    always_comb begin
        if (word_op) begin
            fmt_data = {{(XLEN-WLEN){sel_data[WLEN-1]}}, sel_data[WLEN-1:0]};
        end else begin
            fmt_data = sel_data;
        end
    end

    // ------------------------------------------------------------------
    // Response buffer
    // ------------------------------------------------------------------

    // Valid from the cycle after completion until consumed
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            resp_valid <= 1'b0;
        end else if (out_valid) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    // Data captured once per divide
    // No new divide can finish while a response waits, so it holds
    always_ff @(posedge clk) begin
        if (out_valid) begin
            resp_data <= fmt_data;
        end
    end

    // Pending response blocks new requests in the decoder
    assign res_busy = resp_valid;

endmodule

`default_nettype wire

/* hw/div_iter_core.sv */
`timescale 1ns/1ps
`default_nettype none
//--------------------------------------------------------------------
// Iterative restoring divider, one quotient bit per cycle
// Works on magnitudes and restores signs at the end, sharing the
// operand negators. Zero divisor and signed overflow finish at once
//--------------------------------------------------------------------

module div_iter_core
    import rvm_div_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            div_valid,
    input  logic            div_signed,
    input  logic [XLEN-1:0] dividend,
    input  logic [XLEN-1:0] divisor,
    output logic            out_valid,
    output logic [XLEN-1:0] quotient,
    output logic [XLEN-1:0] remainder
);

    // ------------------------------------------------------------------
    // Declarations
    // ------------------------------------------------------------------

    // Step counter, zero in the load cycle
    logic [CNT_W-1:0]  count;

    // Operand signs, only meaningful for signed ops
    logic              dividend_neg;
    logic              divisor_neg;
    logic              quotient_neg;

    // Special cases
    logic              div_by_zero;
    logic              sgn_overflow;

    // Shared two's complement negators
    logic [XLEN-1:0]   neg_in_a;
    logic [XLEN-1:0]   neg_in_b;
    logic [XLEN-1:0]   neg_out_a;
    logic [XLEN-1:0]   neg_out_b;

    // Magnitudes
    logic [XLEN-1:0]   dividend_abs;
    logic [XLEN-1:0]   divisor_abs;

    // Partial remainder in the upper half, quotient bits in the lower
    logic [2*XLEN-1:0] acc;
    logic [2*XLEN-1:0] acc_next;

    // Trial subtraction, one extra bit for the borrow
    logic [XLEN:0]     trial;

    // ------------------------------------------------------------------
    // Step counter
    // ------------------------------------------------------------------

    // Restarts whenever no divide is running or one has just finished
    always_ff @(posedge clk) begin
        if (!rst_n || flush || !div_valid || out_valid) begin
            count <= '0;
        end else begin
            count <= count + CNT_W'(1);
        end
    end

    // ------------------------------------------------------------------
    // Sign and special case detection
    // ------------------------------------------------------------------

    assign dividend_neg = div_signed & dividend[XLEN-1];
    assign divisor_neg  = div_signed & divisor[XLEN-1];

    // Quotient negative when exactly one operand is
    assign quotient_neg = dividend_neg ^ divisor_neg;

    assign div_by_zero  = (divisor == '0);

    // Most negative value over minus one
    assign sgn_overflow = div_signed
                        & (dividend == {1'b1, {(XLEN-1){1'b0}}})
                        & (divisor == {XLEN{1'b1}});

    // ------------------------------------------------------------------
    // Negators
    // ------------------------------------------------------------------

    // Operands at load time, raw results once out_valid is up
    assign neg_in_a  = out_valid ? acc[2*XLEN-1:XLEN] : dividend;
    assign neg_in_b  = out_valid ? acc[XLEN-1:0] : divisor;
    assign neg_out_a = ~neg_in_a + XLEN'(1);
    assign neg_out_b = ~neg_in_b + XLEN'(1);

    assign dividend_abs = dividend_neg ? neg_out_a : dividend;
    assign divisor_abs  = divisor_neg ? neg_out_b : divisor;

    // ------------------------------------------------------------------
    // Shift-subtract datapath
    // ------------------------------------------------------------------

    // Upper half plus the next dividend bit, minus the divisor
    assign trial = acc[2*XLEN-1:XLEN-1] - {1'b0, divisor_abs};

    // Borrow means restore and shift in a zero
    always_comb begin
        if (trial[XLEN]) begin
            acc_next = {acc[2*XLEN-2:0], 1'b0};
        end else begin
            acc_next = {trial[XLEN-1:0], acc[XLEN-2:0], 1'b1};
        end
    end

    // Load magnitude in the first cycle, then one step per cycle
    always_ff @(posedge clk) begin
        if (count == '0) begin
            acc <= {{XLEN{1'b0}}, dividend_abs};
        end else begin
            acc <= acc_next;
        end
    end

    // Normal end after DIV_STEPS, special cases in the first cycle
    assign out_valid = div_valid
                     & ((count == CNT_W'(DIV_STEPS)) | div_by_zero | sgn_overflow);

    // ------------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------------

    always_comb begin
        if (div_by_zero) begin
            quotient = {XLEN{1'b1}};
        end else if (sgn_overflow) begin
            quotient = dividend;
        end else if (quotient_neg) begin
            quotient = neg_out_b;
        end else begin
            quotient = acc[XLEN-1:0];
        end
    end

    // Remainder follows the dividend sign
    always_comb begin
        if (div_by_zero) begin
            remainder = dividend;
        end else if (sgn_overflow) begin
            remainder = '0;
        end else if (dividend_neg) begin
            remainder = neg_out_a;
        end else begin
            remainder = acc[2*XLEN-1:XLEN];
        end
    end

endmodule

`default_nettype wire

/* hw/div_op_decode.sv */
`timescale 1ns/1ps
`default_nettype none
//--------------------------------------------------------------------
// Request front end of the divider
// Accepts one request, decodes funct3 and holds extended operands
// stable for the iterative core until it reports completion
//--------------------------------------------------------------------

module div_op_decode
    import rvm_div_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            flush,
    input  logic            req_valid,
    input  logic [2:0]      funct3,
    input  logic            word,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    input  logic            out_valid,
    input  logic            res_busy,
    output logic            req_ready,
    output logic [XLEN-1:0] dividend,
    output logic [XLEN-1:0] divisor,
    output logic            div_signed,
    output logic            div_valid,
    output logic            rem_sel,
    output logic            word_op
);

    logic dec_signed;
    logic dec_rem;
    logic accept;

    // Low word extended to XLEN for W forms, else passed as is
    function automatic logic [XLEN-1:0] extend_op(
        input logic [XLEN-1:0] op,
        input logic            is_word,
        input logic            is_signed
    );
        logic fill;
        fill = is_signed & op[WLEN-1];
        if (is_word) begin
            return {{(XLEN-WLEN){fill}}, op[WLEN-1:0]};
        end
        return op;
    endfunction

    // funct3 to signedness and quotient/remainder select
    always_comb begin
        case (funct3)
            FUNCT3_DIV:  begin dec_signed = 1'b1; dec_rem = 1'b0; end
            FUNCT3_DIVU: begin dec_signed = 1'b0; dec_rem = 1'b0; end
            FUNCT3_REM:  begin dec_signed = 1'b1; dec_rem = 1'b1; end
            FUNCT3_REMU: begin dec_signed = 1'b0; dec_rem = 1'b1; end
            // Non-divide codes fall back to DIV
            default:     begin dec_signed = 1'b1; dec_rem = 1'b0; end
        endcase
    end

    // Idle only with no divide running and no response waiting
    assign req_ready = ~div_valid & ~res_busy;
    assign accept    = req_valid & req_ready & ~flush;

    // div_valid doubles as the busy flag, accept to completion
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            div_valid <= 1'b0;
        end else if (accept) begin
            div_valid <= 1'b1;
        end else if (out_valid) begin
            div_valid <= 1'b0;
        end
    end

    // Request fields, held until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            dividend   <= extend_op(rs1, word, dec_signed);
            divisor    <= extend_op(rs2, word, dec_signed);
            div_signed <= dec_signed;
            rem_sel    <= dec_rem;
            word_op    <= word;
        end
    end

endmodule

`default_nettype wire

/* hw/rvm_div_pkg.sv */
`default_nettype none
//--------------------------------------------------------------------
// Shared constants for the RV64M division unit
// Data and word widths, divider step count and the funct3 codes
// Imported by wildcard in every RTL module and the testbench
//--------------------------------------------------------------------

package rvm_div_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------

    // Register width of the core
    localparam int XLEN = 64;

    // Width of the W-form operations
    localparam int WLEN = 32;

    // ------------------------------------------------------------------
    // Iteration control
    // ------------------------------------------------------------------

    // Count at which a normal divide is done
    // One load cycle, then one shift-subtract step per bit
    localparam int DIV_STEPS = XLEN + 1;

    // Step counter width, must hold DIV_STEPS
    localparam int CNT_W = 7;

    // ------------------------------------------------------------------
    // funct3 codes of the M-extension divide group
    // ------------------------------------------------------------------

    localparam logic [2:0] FUNCT3_DIV  = 3'd4;
    localparam logic [2:0] FUNCT3_DIVU = 3'd5;
    localparam logic [2:0] FUNCT3_REM  = 3'd6;
    localparam logic [2:0] FUNCT3_REMU = 3'd7;

endpackage

`default_nettype wire
